// File: logic/stepper_cfg.svh
// peripheral base address, register offsets, spi clock divider and channel counts
`ifndef STEPPER_CFG_SVH
`define STEPPER_CFG_SVH

// start of the peripheral window on the bus
`define STEPPER_PERIPH_BASE 32'h1000_0000

// register offsets inside the window
`define REG_LEDS        8'h00
`define REG_SPI_TX      8'h04
`define REG_SPI_RX      8'h08
`define REG_SPI_CTRL    8'h0C
`define REG_SPI_STATUS  8'h10
`define REG_RC_WIDTH    8'h14
`define REG_MOTOR_EN    8'h18
`define REG_STEP_CMD    8'h1C
`define REG_STEP_STATUS 8'h20

// clock cycles per half sck period
`define SPI_CLK_DIV     4

`define SPI_CS_COUNT    12
`define RC_CHANNELS     2
`define MOTOR_COUNT     12

`endif

// File: logic/stepper_bus_pkg.sv
// bus word type and register selector enum
package stepper_bus_pkg;

  // one data word on the peripheral bus
  typedef logic [31:0] reg_word_t;

  // decoded register select
  // SEL_NONE covers every unmapped offset
  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_LEDS,
    SEL_SPI_TX,
    SEL_SPI_RX,
    SEL_SPI_CTRL,
    SEL_SPI_STATUS,
    SEL_RC_WIDTH,
    SEL_MOTOR_EN,
    SEL_STEP_CMD,
    SEL_STEP_STATUS
  } reg_sel_t;

endpackage

// File: logic/stepper_io_pkg.sv
// step command, spi control word and rc width types
package stepper_io_pkg;

  // move request as written to REG_STEP_CMD
  typedef struct packed {
    logic [2:0]  spare;
    logic        dir;
    logic [11:0] period;  // cycles between pulses, 2 or more
    logic [15:0] count;
  } step_cmd_t;

  // REG_SPI_CTRL layout
  typedef struct packed {
    logic [26:0] spare;
    logic [3:0]  cs_sel;
    logic        start;
  } spi_ctrl_t;

  // high time in clock cycles, saturating
  typedef logic [15:0] rc_width_t;

endpackage

// File: logic/mem_bus_if.sv
// valid/ready peripheral bus interface with master and slave modports
`timescale 1ns/1ps

interface mem_bus_if;
  import stepper_bus_pkg::*;

  logic        valid;
  logic        write;
  logic [31:0] addr;
  reg_word_t   wdata;
  reg_word_t   rdata;
  // one cycle pulse that ends the access
  logic        ready;

  modport master (
    output valid,
    output write,
    output addr,
    output wdata,
    input  rdata,
    input  ready
  );

  modport slave (
    input  valid,
    input  write,
    input  addr,
    input  wdata,
    output rdata,
    output ready
  );

endinterface

// File: logic/io_register.sv
// control register of any payload type with load strobe and written pulse
`timescale 1ns/1ps

module io_register #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_in,
  input  logic     rst_n,
  input  logic     load,
  input  payload_t d,
  output payload_t q,
  output logic     written
);

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      q       <= '0;
      written <= 1'b0;
    end else begin
      // high for the cycle right after a load
      written <= load;
      if (load) begin
        q <= d;
      end
    end
  end

endmodule

// File: logic/periph_regs.sv
// address decode, control registers, read-back mux and bus ready
`timescale 1ns/1ps
`include "stepper_cfg.svh"

module periph_regs (
  input  logic                                         clk_in,
  input  logic                                         rst_n,
  mem_bus_if.slave                                     bus,
  output logic [7:0]                                   led,
  output logic [`MOTOR_COUNT-1:0]                      motor_en_n,
  output stepper_bus_pkg::reg_word_t                   spi_tx,
  output logic [3:0]                                   spi_cs_sel,
  output logic                                         spi_start,
  input  stepper_bus_pkg::reg_word_t                   spi_rx,
  input  logic                                         spi_ready,
  input  stepper_io_pkg::rc_width_t [`RC_CHANNELS-1:0] rc_width,
  output stepper_io_pkg::step_cmd_t                    step_cmd,
  output logic                                         step_start,
  input  logic                                         step_done
);
  import stepper_bus_pkg::*;
  import stepper_io_pkg::*;

  localparam reg_word_t PERIPH_BASE = `STEPPER_PERIPH_BASE;

  reg_sel_t                sel;
  logic                    access;
  logic                    wr_en;
  logic                    ready_q;
  reg_word_t               rdata_q;
  reg_word_t               read_mux;
  logic [`MOTOR_COUNT-1:0] motor_en;
  spi_ctrl_t               spi_ctrl;
  logic                    spi_ctrl_written;
  logic                    step_cmd_written;

  // first cycle of a request, ready is not yet up
  assign access = bus.valid && !ready_q;
  assign wr_en  = access && bus.write;

  always_comb begin
    sel = SEL_NONE;
    if (bus.addr[31:8] == PERIPH_BASE[31:8]) begin
      case (bus.addr[7:0])
        `REG_LEDS:        sel = SEL_LEDS;
        `REG_SPI_TX:      sel = SEL_SPI_TX;
        `REG_SPI_RX:      sel = SEL_SPI_RX;
        `REG_SPI_CTRL:    sel = SEL_SPI_CTRL;
        `REG_SPI_STATUS:  sel = SEL_SPI_STATUS;
        `REG_RC_WIDTH:    sel = SEL_RC_WIDTH;
        `REG_MOTOR_EN:    sel = SEL_MOTOR_EN;
        `REG_STEP_CMD:    sel = SEL_STEP_CMD;
        `REG_STEP_STATUS: sel = SEL_STEP_STATUS;
        default:          sel = SEL_NONE;
      endcase
    end
  end

  io_register #(.payload_t(logic [7:0])) u_leds_reg (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .load    (wr_en && sel == SEL_LEDS),
    .d       (bus.wdata[7:0]),
    .q       (led),
    .written ()
  );

  io_register #(.payload_t(reg_word_t)) u_spi_tx_reg (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .load    (wr_en && sel == SEL_SPI_TX),
    .d       (bus.wdata),
    .q       (spi_tx),
    .written ()
  );

  io_register #(.payload_t(spi_ctrl_t)) u_spi_ctrl_reg (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .load    (wr_en && sel == SEL_SPI_CTRL),
    .d       (spi_ctrl_t'(bus.wdata)),
    .q       (spi_ctrl),
    .written (spi_ctrl_written)
  );

  io_register #(.payload_t(logic [`MOTOR_COUNT-1:0])) u_motor_en_reg (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .load    (wr_en && sel == SEL_MOTOR_EN),
    .d       (bus.wdata[`MOTOR_COUNT-1:0]),
    .q       (motor_en),
    .written ()
  );

  io_register #(.payload_t(step_cmd_t)) u_step_cmd_reg (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .load    (wr_en && sel == SEL_STEP_CMD),
    .d       (step_cmd_t'(bus.wdata)),
    .q       (step_cmd),
    .written (step_cmd_written)
  );

  // driver enables are active low on the board
  assign motor_en_n = ~motor_en;

  // start strobes, one cycle after the register write
  assign spi_start  = spi_ctrl_written && spi_ctrl.start;
  assign spi_cs_sel = spi_ctrl.cs_sel;
  assign step_start = step_cmd_written && (step_cmd.count != '0);

  always_comb begin
    case (sel)
      SEL_LEDS:        read_mux = reg_word_t'(led);
      SEL_SPI_TX:      read_mux = spi_tx;
      SEL_SPI_RX:      read_mux = spi_rx;
      SEL_SPI_CTRL:    read_mux = reg_word_t'(spi_ctrl);
      SEL_SPI_STATUS:  read_mux = reg_word_t'(spi_ready);
      SEL_RC_WIDTH:    read_mux = reg_word_t'(rc_width);
      SEL_MOTOR_EN:    read_mux = reg_word_t'(motor_en);
      SEL_STEP_CMD:    read_mux = reg_word_t'(step_cmd);
      SEL_STEP_STATUS: read_mux = reg_word_t'(step_done);
      default:         read_mux = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  // read data sampled at the edge that raises ready
  always_ff @(posedge clk_in) begin
    if (access) begin
      rdata_q <= bus.write ? '0 : read_mux;
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

endmodule

// File: logic/spi_master.sv
// 32-bit mode 0 spi master with clock divider and chip select decode
`timescale 1ns/1ps
`include "stepper_cfg.svh"

module spi_master (
  input  logic                       clk_in,
  input  logic                       rst_n,
  input  logic                       start,
  input  stepper_bus_pkg::reg_word_t tx,
  input  logic [3:0]                 cs_sel,
  input  logic                       miso,
  output stepper_bus_pkg::reg_word_t rx,
  output logic                       ready,
  output logic                       sck,
  output logic                       mosi,
  output logic [`SPI_CS_COUNT-1:0]   cs_n
);
  import stepper_bus_pkg::*;

  localparam int DIV_W = $clog2(`SPI_CLK_DIV + 1);

  logic             busy;
  logic [DIV_W-1:0] div_cnt;
  logic [4:0]       bit_cnt;
  logic [3:0]       cs_q;
  reg_word_t        shreg;
  logic             miso_bit;
  logic             half_done;
  logic             rise_tick;
  logic             fall_tick;

  assign half_done = (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
  assign rise_tick = busy && half_done && !sck;
  assign fall_tick = busy && half_done && sck;

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      sck     <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      cs_q    <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        div_cnt <= '0;
        bit_cnt <= '0;
        cs_q    <= cs_sel;
      end
    end else if (half_done) begin
      div_cnt <= '0;
      sck     <= !sck;
      // bit ends on the falling edge
      if (sck) begin
        bit_cnt <= bit_cnt + 5'd1;
        if (bit_cnt == 5'd31) begin
          busy <= 1'b0;
        end
      end
    end else begin
      div_cnt <= div_cnt + DIV_W'(1);
    end
  end

  // miso taken on rising sck, shifted in on the falling one
  always_ff @(posedge clk_in) begin
    if (start && !busy) begin
      shreg <= tx;
    end else if (rise_tick) begin
      miso_bit <= miso;
    end else if (fall_tick) begin
      shreg <= {shreg[30:0], miso_bit};
      if (bit_cnt == 5'd31) begin
        rx <= {shreg[30:0], miso_bit};
      end
    end
  end

  assign mosi  = shreg[31];
  assign ready = !busy;

  // an index above the line count leaves all lines high
  always_comb begin
    for (int i = 0; i < `SPI_CS_COUNT; i++) begin
      cs_n[i] = !(busy && cs_q == 4'(i));
    end
  end

endmodule

// File: logic/pwm_capture.sv
// rc pulse synchronizer and saturating high-time counter
`timescale 1ns/1ps

module pwm_capture (
  input  logic                      clk_in,
  input  logic                      rst_n,
  input  logic                      pulse,
  output stepper_io_pkg::rc_width_t width
);
  import stepper_io_pkg::*;

  logic [1:0] sync;
  logic       pulse_d;
  logic       fall;
  rc_width_t  high_cnt;

  assign fall = pulse_d && !sync[1];

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      sync     <= '0;
      pulse_d  <= 1'b0;
      high_cnt <= '0;
      width    <= '0;
    end else begin
      sync    <= {sync[0], pulse};
      pulse_d <= sync[1];
      if (fall) begin
        // latch the finished pulse, restart for the next one
        width    <= high_cnt;
        high_cnt <= '0;
      end else if (sync[1] && high_cnt != '1) begin
        high_cnt <= high_cnt + 1'b1;
      end
    end
  end

endmodule

// File: logic/step_generator.sv
// step pulse generator with fixed period, direction hold and done level
`timescale 1ns/1ps

module step_generator (
  input  logic                      clk_in,
  input  logic                      rst_n,
  input  logic                      start,
  input  stepper_io_pkg::step_cmd_t cmd,
  output logic                      step,
  output logic                      dir,
  output logic                      done
);

  logic        busy;
  logic [11:0] period_q;
  logic [11:0] tick_cnt;
  logic [15:0] remaining;
  logic        tick_last;

  // last cycle of the current period
  assign tick_last = (tick_cnt == period_q - 12'd1);
  assign done      = !busy;

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      period_q  <= '0;
      tick_cnt  <= '0;
      remaining <= '0;
      step      <= 1'b0;
      dir       <= 1'b0;
    end else begin
      step <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy      <= 1'b1;
          period_q  <= cmd.period;
          dir       <= cmd.dir;
          remaining <= cmd.count;
          // the start cycle counts as cycle 0
          tick_cnt  <= 12'd1;
        end
      end else if (tick_last) begin
        tick_cnt <= '0;
        if (remaining != '0) begin
          step      <= 1'b1;
          remaining <= remaining - 16'd1;
        end else begin
          // one idle period after the final pulse
          busy <= 1'b0;
        end
      end else begin
        tick_cnt <= tick_cnt + 12'd1;
      end
    end
  end

endmodule

// File: logic/stepper_top.sv
// stepper peripheral top level with bus, spi, rc capture and step outputs
`timescale 1ns/1ps
`include "stepper_cfg.svh"

module stepper_top (
  input  logic                       clk_in,
  input  logic                       rst_n,
  input  logic                       bus_valid,
  input  logic                       bus_write,
  input  logic [31:0]                bus_addr,
  input  stepper_bus_pkg::reg_word_t bus_wdata,
  output stepper_bus_pkg::reg_word_t bus_rdata,
  output logic                       bus_ready,
  output logic [7:0]                 led,
  output logic                       spi_sck,
  output logic                       spi_mosi,
  output logic [`SPI_CS_COUNT-1:0]   spi_cs_n,
  input  logic                       spi_miso,
  input  logic [`RC_CHANNELS-1:0]    rc_pulse,
  output logic [`MOTOR_COUNT-1:0]    motor_en_n,
  output logic                       step,
  output logic                       dir
);
  import stepper_bus_pkg::*;
  import stepper_io_pkg::*;

  reg_word_t                   spi_tx;
  reg_word_t                   spi_rx;
  logic [3:0]                  spi_cs_sel;
  logic                        spi_start;
  logic                        spi_ready;
  rc_width_t [`RC_CHANNELS-1:0] rc_width;
  step_cmd_t                   step_cmd;
  logic                        step_start;
  logic                        step_done;

  mem_bus_if u_bus ();

  assign u_bus.valid = bus_valid;
  assign u_bus.write = bus_write;
  assign u_bus.addr  = bus_addr;
  assign u_bus.wdata = bus_wdata;
  assign bus_rdata   = u_bus.rdata;
  assign bus_ready   = u_bus.ready;

  periph_regs u_periph_regs (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .bus        (u_bus.slave),
    .led        (led),
    .motor_en_n (motor_en_n),
    .spi_tx     (spi_tx),
    .spi_cs_sel (spi_cs_sel),
    .spi_start  (spi_start),
    .spi_rx     (spi_rx),
    .spi_ready  (spi_ready),
    .rc_width   (rc_width),
    .step_cmd   (step_cmd),
    .step_start (step_start),
    .step_done  (step_done)
  );

  spi_master u_spi_master (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .start  (spi_start),
    .tx     (spi_tx),
    .cs_sel (spi_cs_sel),
    .miso   (spi_miso),
    .rx     (spi_rx),
    .ready  (spi_ready),
    .sck    (spi_sck),
    .mosi   (spi_mosi),
    .cs_n   (spi_cs_n)
  );

  // one capture per rc channel
  for (genvar ch = 0; ch < `RC_CHANNELS; ch++) begin : g_rc
    pwm_capture u_pwm_capture (
      .clk_in (clk_in),
      .rst_n  (rst_n),
      .pulse  (rc_pulse[ch]),
      .width  (rc_width[ch])
    );
  end

  step_generator u_step_generator (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .start  (step_start),
    .cmd    (step_cmd),
    .step   (step),
    .dir    (dir),
    .done   (step_done)
  );

endmodule

// File: test/tb_stepper.sv
// table-driven bus master testbench for stepper_top with spi loopback and step monitor
`timescale 1ns/1ps
`include "stepper_cfg.svh"

module tb_stepper;
  import stepper_bus_pkg::*;
  import stepper_io_pkg::*;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_RC,
    OP_WAIT_SPI,
    OP_WAIT_MOVE
  } op_t;

  // addr is the channel for OP_RC
  // data is the cs index for OP_WAIT_SPI and the period for OP_WAIT_MOVE
  typedef struct packed {
    op_t         op;
    logic [31:0] addr;
    reg_word_t   data;
    reg_word_t   exp_val;
  } entry_t;

  logic                     clk_in;
  logic                     rst_n;
  logic                     bus_valid;
  logic                     bus_write;
  logic [31:0]              bus_addr;
  reg_word_t                bus_wdata;
  reg_word_t                bus_rdata;
  logic                     bus_ready;
  logic [7:0]               led;
  logic                     spi_sck;
  logic                     spi_mosi;
  logic [`SPI_CS_COUNT-1:0] spi_cs_n;
  logic                     spi_miso;
  logic [`RC_CHANNELS-1:0]  rc_pulse;
  logic [`MOTOR_COUNT-1:0]  motor_en_n;
  logic                     step;
  logic                     dir;

  entry_t                  stim[$];
  logic [31:0]             rng_state = 32'd50;
  int                      cycle_cnt = 0;
  int                      cycle_limit = 0;
  logic                    mosi_d = 1'b0;
  logic [7:0]              led_model = '0;
  logic [`MOTOR_COUNT-1:0] en_model = '0;
  // step model, set when a move is accepted
  logic                    move_busy = 1'b0;
  logic [11:0]             exp_period = '0;
  logic                    exp_dir = 1'b0;
  int                      pulse_cnt = 0;
  int                      last_step_cycle = 0;

  stepper_top u_stepper_top (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .bus_valid  (bus_valid),
    .bus_write  (bus_write),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata),
    .bus_ready  (bus_ready),
    .led        (led),
    .spi_sck    (spi_sck),
    .spi_mosi   (spi_mosi),
    .spi_cs_n   (spi_cs_n),
    .spi_miso   (spi_miso),
    .rc_pulse   (rc_pulse),
    .motor_en_n (motor_en_n),
    .step       (step),
    .dir        (dir)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_width(input string name, input rc_width_t got, input rc_width_t exp);
    if (got !== exp) begin
      report_failure($sformatf("error %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bits(input string name, input logic [11:0] got,
                            input logic [11:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("error %s: got %h expected %h", name, got, exp));
    end
  endtask

  // 32-bit xorshift
  function automatic reg_word_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [7:0] offset);
    return `STEPPER_PERIPH_BASE + {24'd0, offset};
  endfunction

  function automatic void add_entry(input op_t op, input logic [31:0] addr,
                                    input reg_word_t data, input reg_word_t exp_val);
    entry_t e;
    e.op      = op;
    e.addr    = addr;
    e.data    = data;
    e.exp_val = exp_val;
    stim.push_back(e);
  endfunction

  // worst-case clock cycles an entry may take
  function automatic int entry_cycles(input entry_t e);
    case (e.op)
      OP_RC:        return int'(e.data) + 12;
      OP_WAIT_SPI:  return 64 * `SPI_CLK_DIV + 16;
      OP_WAIT_MOVE: return (int'(e.exp_val) + 2) * int'(e.data) + 16;
      default:      return 4;
    endcase
  endfunction

  function automatic void build_table();
    reg_word_t w;
    add_entry(OP_READ, reg_addr(`REG_STEP_STATUS), '0, 32'd1);
    add_entry(OP_READ, reg_addr(`REG_SPI_STATUS), '0, 32'd1);
    add_entry(OP_READ, reg_addr(`REG_RC_WIDTH), '0, '0);
    add_entry(OP_READ, reg_addr(8'h40), '0, '0);
    add_entry(OP_READ, 32'h2000_0004, '0, '0);
    // read-only register ignores the write
    add_entry(OP_WRITE, reg_addr(`REG_STEP_STATUS), next_random(), '0);
    add_entry(OP_READ, reg_addr(`REG_STEP_STATUS), '0, 32'd1);
    w = next_random();
    add_entry(OP_WRITE, reg_addr(`REG_LEDS), w, '0);
    add_entry(OP_READ, reg_addr(`REG_LEDS), '0, w & 32'h0000_00ff);
    w = next_random();
    add_entry(OP_WRITE, reg_addr(`REG_MOTOR_EN), w, '0);
    add_entry(OP_READ, reg_addr(`REG_MOTOR_EN), '0, w & 32'h0000_0fff);
    w = next_random();
    add_entry(OP_WRITE, reg_addr(`REG_SPI_TX), w, '0);
    add_entry(OP_READ, reg_addr(`REG_SPI_TX), '0, w);
    // loopback transfer on chip select 5
    w = next_random();
    add_entry(OP_WRITE, reg_addr(`REG_SPI_TX), w, '0);
    add_entry(OP_WRITE, reg_addr(`REG_SPI_CTRL), 32'h0000_000b, '0);
    add_entry(OP_WAIT_SPI, '0, 32'd5, '0);
    add_entry(OP_READ, reg_addr(`REG_SPI_STATUS), '0, 32'd1);
    add_entry(OP_READ, reg_addr(`REG_SPI_RX), '0, w);
    add_entry(OP_READ, reg_addr(`REG_SPI_CTRL), '0, 32'h0000_000b);
    add_entry(OP_RC, 32'd0, 32'd150, '0);
    add_entry(OP_RC, 32'd1, 32'd300, '0);
    add_entry(OP_READ, reg_addr(`REG_RC_WIDTH), '0, {16'd300, 16'd150});
    // count 7, period 10, dir 1, then a second command while busy
    add_entry(OP_WRITE, reg_addr(`REG_STEP_CMD), 32'h100a_0007, '0);
    add_entry(OP_READ, reg_addr(`REG_STEP_STATUS), '0, '0);
    add_entry(OP_WRITE, reg_addr(`REG_STEP_CMD), 32'h0005_0003, '0);
    add_entry(OP_WAIT_MOVE, '0, 32'd10, 32'd7);
    add_entry(OP_READ, reg_addr(`REG_STEP_STATUS), '0, 32'd1);
    // register keeps the ignored command
    add_entry(OP_READ, reg_addr(`REG_STEP_CMD), '0, 32'h0005_0003);
  endfunction

  // one bus access, returns after the ready cycle
  task automatic access_reg(input logic write, input logic [31:0] addr,
                            input reg_word_t wdata, output reg_word_t rdata);
    @(negedge clk_in);
    bus_valid = 1'b1;
    bus_write = write;
    bus_addr  = addr;
    bus_wdata = wdata;
    do begin
      @(negedge clk_in);
    end while (!bus_ready);
    rdata     = bus_rdata;
    bus_valid = 1'b0;
    bus_write = 1'b0;
  endtask

  task automatic run_entry(input entry_t e);
    reg_word_t rd;
    step_cmd_t cmd;
    logic [11:0] cs_low;
    logic seen_low;
    int sck_rises;
    logic sck_prev;
    case (e.op)
      OP_WRITE: begin
        access_reg(1'b1, e.addr, e.data, rd);
        if (e.addr == reg_addr(`REG_LEDS)) led_model = e.data[7:0];
        if (e.addr == reg_addr(`REG_MOTOR_EN)) en_model = e.data[`MOTOR_COUNT-1:0];
        if (e.addr == reg_addr(`REG_STEP_CMD)) begin
          cmd = step_cmd_t'(e.data);
          if (!move_busy && cmd.count != '0) begin
            move_busy  = 1'b1;
            exp_period = cmd.period;
            exp_dir    = cmd.dir;
            pulse_cnt  = 0;
          end
        end
        check_word("led", reg_word_t'(led), reg_word_t'(led_model));
        check_bits("motor_en_n", motor_en_n, ~en_model);
      end
      OP_READ: begin
        access_reg(1'b0, e.addr, '0, rd);
        check_word($sformatf("bus_rdata[%h]", e.addr), rd, e.exp_val);
      end
      OP_RC: begin
        @(negedge clk_in);
        rc_pulse[e.addr[0]] = 1'b1;
        repeat (int'(e.data)) @(negedge clk_in);
        rc_pulse[e.addr[0]] = 1'b0;
        // synchronizer and falling edge latency
        repeat (6) @(negedge clk_in);
        access_reg(1'b0, reg_addr(`REG_RC_WIDTH), '0, rd);
        check_width($sformatf("rc_width[%0d]", e.addr[0]),
                    e.addr[0] ? rd[31:16] : rd[15:0], e.data[15:0]);
      end
      OP_WAIT_SPI: begin
        cs_low    = ~(12'h001 << e.data[3:0]);
        seen_low  = 1'b0;
        sck_rises = 0;
        sck_prev  = spi_sck;
        do begin
          @(negedge clk_in);
          if (spi_sck && !sck_prev) begin
            sck_rises++;
          end
          sck_prev = spi_sck;
          if (spi_cs_n == cs_low) begin
            seen_low = 1'b1;
          end else begin
            check_bits("spi_cs_n", spi_cs_n, 12'hfff);
          end
        end while (!(seen_low && spi_cs_n == 12'hfff));
        // one rising sck edge per bit of the word
        check_word("spi_sck rising edges", reg_word_t'(sck_rises), 32'd32);
      end
      OP_WAIT_MOVE: begin
        do begin
          access_reg(1'b0, reg_addr(`REG_STEP_STATUS), '0, rd);
          check_word("dir", reg_word_t'(dir), reg_word_t'(exp_dir));
        end while (rd != 32'd1);
        check_word("step pulse count", reg_word_t'(pulse_cnt), e.exp_val);
        move_busy = 1'b0;
      end
      default: report_failure("unknown operation in the stimulus table");
    endcase
  endtask

  // one clock delay from mosi back to miso
  always @(negedge clk_in) begin
    spi_miso = mosi_d;
    mosi_d   = spi_mosi;
  end

  // step pulse counter and spacing check
  always @(negedge clk_in) begin
    if (rst_n && step) begin
      if (!move_busy) begin
        report_failure("step pulse seen while no move was running");
      end else begin
        if (pulse_cnt != 0) begin
          check_word("step pulse spacing", reg_word_t'(cycle_cnt - last_step_cycle),
                     reg_word_t'(exp_period));
        end
        check_word("dir", reg_word_t'(dir), reg_word_t'(exp_dir));
        pulse_cnt++;
        last_step_cycle = cycle_cnt;
      end
    end
  end

  always @(posedge clk_in) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      report_failure($sformatf("simulation timed out after %0d cycles", cycle_cnt));
    end
  end

  initial begin
    rst_n     = 1'b0;
    bus_valid = 1'b0;
    bus_write = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    spi_miso  = 1'b0;
    rc_pulse  = '0;
    build_table();
    cycle_limit = 4 + 2000;
    foreach (stim[i]) begin
      cycle_limit += entry_cycles(stim[i]);
    end

    repeat (4) @(negedge clk_in);
    rst_n = 1'b1;
    check_word("led", reg_word_t'(led), '0);
    check_bits("motor_en_n", motor_en_n, 12'hfff);
    check_bits("spi_cs_n", spi_cs_n, 12'hfff);
    check_word("bus_ready", reg_word_t'(bus_ready), '0);
    check_word("step", reg_word_t'(step), '0);
    check_word("spi_sck", reg_word_t'(spi_sck), '0);

    foreach (stim[i]) begin
      run_entry(stim[i]);
    end
    repeat (4) @(negedge clk_in);

    $display("Regression passed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+logic
logic/stepper_bus_pkg.sv
logic/stepper_io_pkg.sv
logic/mem_bus_if.sv
logic/io_register.sv
logic/periph_regs.sv
logic/spi_master.sv
logic/pwm_capture.sv
logic/step_generator.sv
logic/stepper_top.sv
test/tb_stepper.sv

// File: run_sim.sh
#!/bin/sh
# builds the stepper testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "could not create $BUILD_DIR"
  exit 1
fi

verilator --binary --timing -f compile.f --top-module tb_stepper \
  -Mdir "$BUILD_DIR/obj_dir" -o tb_stepper
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BUILD_DIR/obj_dir/tb_stepper" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Regression passed" "$LOG_FILE"; then
  exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
